// ==== bench/rename_golden.txt ====
# rep disp inst retire flush, then dispatch_out: acc rob dest new old
# then retire_out: valid rd dest new old, then ready full (checked on the last rep)
1 0 00000000 0 0 0 0 0 0 0 0 0 0 0 0 1 0
1 0 00000000 1 0 0 0 0 0 0 0 0 0 0 0 1 0
1 1 000000b3 0 0 1 0 1 32 1 0 0 0 0 0 1 0
1 1 00000133 0 0 1 1 1 33 2 0 0 0 0 0 1 0
1 1 000000b3 0 0 1 2 1 34 32 0 0 0 0 0 1 0
1 1 000002a3 0 0 1 3 0 0 0 0 0 0 0 0 1 0
1 1 00000463 0 0 1 4 0 0 0 0 0 0 0 0 1 0
1 1 00000033 0 0 1 5 0 0 0 0 0 0 0 0 1 0
1 0 00000000 1 0 0 6 0 0 0 1 1 1 32 1 1 0
1 1 000001b3 1 0 1 6 1 1 3 1 2 1 33 2 1 0
1 1 00000233 1 0 1 7 1 2 4 1 1 1 34 32 1 0
1 0 00000000 1 0 0 8 0 0 0 1 5 0 0 0 1 0
1 1 000002b3 1 1 0 8 1 32 5 1 8 0 0 0 1 0
1 1 000001b3 0 0 1 5 1 1 3 0 0 0 0 0 1 0
1 1 00000233 0 0 1 6 1 2 4 0 0 0 0 0 1 0
1 1 000000b3 0 0 1 7 1 32 34 0 0 0 0 0 1 0
13 1 000002a3 0 0 1 4 0 0 0 0 0 0 0 0 1 0
1 1 000002a3 0 0 0 5 0 0 0 0 0 0 0 0 0 1
1 0 00000000 0 1 0 5 0 0 0 0 0 0 0 0 0 1
1 1 000002b3 0 0 1 5 1 1 5 0 0 0 0 0 1 0
1 1 00000333 0 0 1 6 1 2 6 0 0 0 0 0 1 0
1 1 000000b3 0 0 1 7 1 32 34 0 0 0 0 0 1 0
13 1 000003b3 0 0 1 4 1 47 46 0 0 0 0 0 1 0
1 1 000003b3 0 0 0 5 1 0 47 0 0 0 0 0 0 1
1 1 000003b3 1 0 0 5 1 0 47 1 5 1 1 5 0 1
1 1 000003b3 0 0 1 5 1 5 47 0 0 0 0 0 1 0
1 0 00000000 1 1 0 6 0 0 0 1 6 1 2 6 0 1
1 1 00000333 0 0 1 7 1 5 2 0 0 0 0 0 1 0
1 1 00000133 0 0 1 8 1 6 33 0 0 0 0 0 1 0
1 0 00000000 0 0 0 9 0 0 0 0 0 0 0 0 1 0

// ==== bench/rename_checks.svh ====
// compare tasks for dispatch results, retire results and the ready and full levels
`ifndef RENAME_CHECKS_SVH
`define RENAME_CHECKS_SVH

    // readable field dump for error lines
    function automatic string show_dispatch(input dispatch_result_t d);
        return $sformatf("acc=%0b rob=%0d dest=%0b new=%0d old=%0d",
                         d.accepted, d.rob_index, d.has_dest, d.new_tag, d.old_tag);
    endfunction

    function automatic string show_retire(input retire_result_t r);
        return $sformatf("valid=%0b rd=%0d dest=%0b new=%0d old=%0d",
                         r.valid, r.rd, r.has_dest, r.new_tag, r.old_tag);
    endfunction

    // whole struct compared, so x or z on any field also counts as a miss
    task automatic check_dispatch(input string name, input dispatch_result_t expected,
                                  input dispatch_result_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED %s dispatch_out expected %s actual %s",
                                name, show_dispatch(expected), show_dispatch(actual)));
        end
    endtask

    task automatic check_retire(input string name, input retire_result_t expected,
                                input retire_result_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED %s retire_out expected %s actual %s",
                                name, show_retire(expected), show_retire(actual)));
        end
    endtask

    // back-pressure levels travel as a pair
    task automatic check_levels(input string name, input logic expected_ready,
                                input logic expected_full, input logic actual_ready,
                                input logic actual_full);
        if (actual_ready !== expected_ready || actual_full !== expected_full) begin
            abort_run($sformatf("CHECK FAILED %s levels expected ready=%0b full=%0b %s",
                                name, expected_ready, expected_full,
                                $sformatf("actual ready=%0b full=%0b",
                                          actual_ready, actual_full)));
        end
    endtask

`endif

// ==== bench/rename_tb.sv ====
// rename core testbench with clock, reset, golden replay, idle gaps and watchdog
module rename_tb import isa_pkg::*, rename_pkg::*; ();

    // one golden record, repeated rep cycles, expected values hold for the last one
    typedef struct packed {
        int               rep;
        logic             dispatch;
        inst_word_t       inst;
        logic             retire;
        logic             flush;
        dispatch_result_t exp_dispatch;
        retire_result_t   exp_retire;
        logic             exp_ready;
        logic             exp_full;
    } golden_line_t;

    logic             clock;
    logic             reset;
    logic             dispatch;
    inst_word_t       inst;
    logic             retire;
    logic             flush;
    dispatch_result_t dispatch_out;
    retire_result_t   retire_out;
    logic             dispatch_ready;
    logic             rob_full;

    golden_line_t golden[$];
    // zero until the golden file is loaded and the run length is known
    int           time_limit = 0;

    `include "rename_checks.svh"

    rename_core rename_core_inst (
        .clock          (clock),
        .reset          (reset),
        .dispatch       (dispatch),
        .inst           (inst),
        .flush          (flush),
        .retire         (retire),
        .dispatch_out   (dispatch_out),
        .retire_out     (retire_out),
        .dispatch_ready (dispatch_ready),
        .rob_full       (rob_full)
    );

    // 20 unit period
    initial clock = 1'b0;
    always #10 clock = ~clock;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic load_golden();
        int           fd;
        int           n;
        int           f[17];
        string        text;
        golden_line_t g;
        fd = $fopen("bench/rename_golden.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open bench/rename_golden.txt for reading");
        end
        while ($fgets(text, fd) > 0) begin
            // blank lines and column notes
            if (text.len() < 2 || text.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(text, "%d %d %h %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                        f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16]);
            if (n != 17) begin
                abort_run($sformatf("golden file line has %0d fields: %s", n, text));
            end else begin
                g.rep                    = f[0];
                g.dispatch               = f[1][0];
                g.inst                   = inst_word_t'(f[2]);
                g.retire                 = f[3][0];
                g.flush                  = f[4][0];
                g.exp_dispatch.accepted  = f[5][0];
                g.exp_dispatch.rob_index = rob_idx_t'(f[6]);
                g.exp_dispatch.has_dest  = f[7][0];
                g.exp_dispatch.new_tag   = phys_tag_t'(f[8]);
                g.exp_dispatch.old_tag   = phys_tag_t'(f[9]);
                g.exp_retire.valid       = f[10][0];
                g.exp_retire.rd          = arch_idx_t'(f[11]);
                g.exp_retire.has_dest    = f[12][0];
                g.exp_retire.new_tag     = phys_tag_t'(f[13]);
                g.exp_retire.old_tag     = phys_tag_t'(f[14]);
                g.exp_ready              = f[15][0];
                g.exp_full               = f[16][0];
                golden.push_back(g);
            end
        end
        $fclose(fd);
    endtask

    initial begin
        int    total;
        int    gap;
        string name;
        void'($urandom(32'h9281_c83f));
        reset    = 1'b1;
        dispatch = 1'b0;
        inst     = '0;
        retire   = 1'b0;
        flush    = 1'b0;
        load_golden();
        total = 0;
        foreach (golden[i]) begin
            total += golden[i].rep;
        end
        // reset, replay cycles, worst idle gaps, then 100 cycles of margin
        time_limit = (16 + total + 2 * golden.size() + 100) * 20;
        repeat (16) @(posedge clock);
        reset <= 1'b0;
        foreach (golden[i]) begin
            for (int j = 0; j < golden[i].rep; j++) begin
                @(posedge clock);
                dispatch <= golden[i].dispatch;
                inst     <= golden[i].inst;
                retire   <= golden[i].retire;
                flush    <= golden[i].flush;
            end
            // outputs are combinational, settled by the falling edge
            @(negedge clock);
            name = $sformatf("golden record %0d", i + 1);
            check_dispatch(name, golden[i].exp_dispatch, dispatch_out);
            check_retire(name, golden[i].exp_retire, retire_out);
            check_levels(name, golden[i].exp_ready, golden[i].exp_full,
                         dispatch_ready, rob_full);
            // idle cycles leave all state untouched
            gap = $urandom % 3;
            repeat (gap) begin
                @(posedge clock);
                dispatch <= 1'b0;
                inst     <= '0;
                retire   <= 1'b0;
                flush    <= 1'b0;
            end
        end
        $display("Verification passed");
        $finish;
    end

    // watchdog
    initial begin
        wait (time_limit != 0);
        #(time_limit);
        abort_run("watchdog timeout, the golden replay did not complete in time");
    end

endmodule

// ==== common/isa_pkg.sv ====
// instruction word formats, the R/S decode union and opcode constants
package isa_pkg;

    // register-register layout, bits 11:7 name the destination
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_format_t;

    // store layout, the same bits 11:7 carry the low immediate
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_format_t;

    // one word, two readings of bits 11:7
    typedef union packed {
        r_format_t r_fields;
        s_format_t s_fields;
    } inst_word_t;

    // major opcodes that never write a register
    localparam logic [6:0] OPC_STORE  = 7'b010_0011;
    localparam logic [6:0] OPC_BRANCH = 7'b110_0011;

endpackage

// ==== common/rename_pkg.sv ====
// physical tag, reorder buffer entry, map array and result structs
`include "rename_settings.svh"

package rename_pkg;

    // physical register number
    typedef logic [`PHYS_IDX_W-1:0] phys_tag_t;

    // slot number inside the reorder buffer
    typedef logic [`ROB_IDX_W-1:0] rob_idx_t;

    // architectural register number
    typedef logic [`ARCH_IDX_W-1:0] arch_idx_t;

    // one tag per architectural register
    typedef phys_tag_t [`ARCH_REGS-1:0] phys_map_t;

    // what the buffer keeps per instruction
    typedef struct packed {
        logic      has_dest;
        arch_idx_t rd;
        phys_tag_t new_tag;
        phys_tag_t old_tag;
    } rob_entry_t;

    // rename outcome of the word on the dispatch port
    typedef struct packed {
        logic      accepted;
        rob_idx_t  rob_index;
        logic      has_dest;
        phys_tag_t new_tag;
        phys_tag_t old_tag;
    } dispatch_result_t;

    // head entry leaving the buffer
    typedef struct packed {
        logic      valid;
        arch_idx_t rd;
        logic      has_dest;
        phys_tag_t new_tag;
        phys_tag_t old_tag;
    } retire_result_t;

endpackage

// ==== common/rename_settings.svh ====
// register counts, index widths and reorder buffer depth for the rename core
`ifndef RENAME_SETTINGS_SVH
`define RENAME_SETTINGS_SVH

// architectural register file as seen by software
`define ARCH_REGS   32
`define ARCH_IDX_W  5

// physical registers behind the rename maps
// the upper sixteen start out free
`define PHYS_REGS   48
`define PHYS_IDX_W  6

// reorder buffer entries, kept a power of two so pointers wrap for free
`define ROB_DEPTH   16
`define ROB_IDX_W   4

`endif

// ==== flist.f ====
+incdir+common
+incdir+bench
common/isa_pkg.sv
common/rename_pkg.sv
rename/free_list.sv
rename/map_table.sv
rename/reorder_buffer.sv
logic/arch_map.sv
rename/rename_core.sv
bench/rename_tb.sv

// ==== logic/arch_map.sv ====
// committed architectural-to-physical map updated at retirement
`include "rename_settings.svh"

module arch_map import rename_pkg::*; (
    input  logic           clock,
    input  logic           reset,
    input  retire_result_t commit,
    output phys_map_t      map_next
);

    phys_map_t map_q;

    // next state is exported, so a flush in a committing cycle
    // restores the speculative map with that commit already applied
    always_comb begin
        map_next = map_q;
        if (commit.valid && commit.has_dest) begin
            map_next[commit.rd] = commit.new_tag;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // same identity start as the speculative map
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map_q[i] <= phys_tag_t'(i);
            end
        end else begin
            map_q <= map_next;
        end
    end

endmodule

// ==== rename/free_list.sv ====
// free physical register bitmap with lowest-first allocation, release and rollback
`include "rename_settings.svh"

module free_list import rename_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  alloc,
    input  retire_result_t        release_out,
    input  logic                  rollback,
    input  logic [`PHYS_REGS-1:0] rollback_mask,
    output phys_tag_t             alloc_tag,
    output logic                  free_empty
);

    // one bit per physical register, set means free
    logic [`PHYS_REGS-1:0] free_q;
    logic [`PHYS_REGS-1:0] free_next;

    // priority encoder, the lowest free index wins
    // scanning downward leaves the lowest hit in place
    always_comb begin
        alloc_tag = '0;
        for (int i = `PHYS_REGS - 1; i >= 0; i--) begin
            if (free_q[i]) begin
                alloc_tag = phys_tag_t'(i);
            end
        end
    end

    assign free_empty = (free_q == '0);

    always_comb begin
        free_next = free_q;
        // taken by the instruction being dispatched
        if (alloc) begin
            free_next[alloc_tag] = 1'b0;
        end
        // a committed writer frees the mapping it replaced
        if (release_out.valid && release_out.has_dest) begin
            free_next[release_out.old_tag] = 1'b1;
        end
        // squashed writers hand their tags back
        if (rollback) begin
            free_next = free_next | rollback_mask;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // the low tags hold the identity map, the rest are spare
            free_q <= '0;
            for (int i = `ARCH_REGS; i < `PHYS_REGS; i++) begin
                free_q[i] <= 1'b1;
            end
        end else begin
            free_q <= free_next;
        end
    end

    // the top level must hold dispatch back once the list runs dry
    a_no_alloc_when_empty: assert property (
        @(posedge clock) disable iff (reset) alloc |-> !free_empty
    ) else $error("free list allocation with no free register");

endmodule

// ==== rename/map_table.sv ====
// speculative architectural-to-physical map with destination decode and restore
`include "rename_settings.svh"

module map_table import isa_pkg::*, rename_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  inst_word_t inst,
    input  logic       write,
    input  phys_tag_t  new_tag,
    input  logic       restore,
    input  phys_map_t  restore_map,
    output logic       has_dest,
    output arch_idx_t  rd,
    output phys_tag_t  old_tag
);

    phys_map_t map_q;
    logic      no_write_op;

    // stores and branches share the S layout, so the opcode is read there
    // and bits 11:7 are immediate bits for them
    assign no_write_op = (inst.s_fields.opcode == OPC_STORE)
                      || (inst.s_fields.opcode == OPC_BRANCH);

    // every other format puts the destination in the R position
    assign rd = inst.r_fields.rd;

    // x0 writes are discarded, so they need no tag
    assign has_dest = !no_write_op && (rd != '0);

    // mapping that this instruction will replace
    assign old_tag = map_q[rd];

    always_ff @(posedge clock) begin
        if (reset) begin
            // identity, x_i lives in p_i
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map_q[i] <= phys_tag_t'(i);
            end
        end else if (restore) begin
            // mispredict recovery, take the committed view wholesale
            map_q <= restore_map;
        end else if (write) begin
            map_q[rd] <= new_tag;
        end
    end

    // x0 stays on p0 through renames and through restores from the committed map
    a_zero_never_remapped: assert property (
        @(posedge clock) disable iff (reset) map_q[0] == '0
    ) else $error("register zero was remapped");

endmodule

// ==== rename/rename_core.sv ====
// rename and retire top level joining free list, maps and reorder buffer
`include "rename_settings.svh"

module rename_core import isa_pkg::*, rename_pkg::*; (
    input  logic             clock,
    input  logic             reset,
    input  logic             dispatch,
    input  inst_word_t       inst,
    input  logic             flush,
    input  logic             retire,
    output dispatch_result_t dispatch_out,
    output retire_result_t   retire_out,
    output logic             dispatch_ready,
    output logic             rob_full
);

    logic                  has_dest;
    arch_idx_t             rd;
    phys_tag_t             old_tag;
    phys_tag_t             alloc_tag;
    logic                  free_empty;
    rob_idx_t              tail;
    logic                  full;
    logic [`PHYS_REGS-1:0] rollback_mask;
    phys_map_t             map_next;
    logic                  accepted;
    logic                  take_tag;
    rob_entry_t            entry;

    // a free tag is only needed when the word writes a register
    assign dispatch_ready = !full && (!has_dest || !free_empty);
    // nothing enters in a flush cycle
    assign accepted = dispatch && dispatch_ready && !flush;
    assign take_tag = accepted && has_dest;

    // non-writers carry zero tags
    assign entry.has_dest = has_dest;
    assign entry.rd       = rd;
    assign entry.new_tag  = has_dest ? alloc_tag : '0;
    assign entry.old_tag  = has_dest ? old_tag : '0;

    assign dispatch_out.accepted  = accepted;
    assign dispatch_out.rob_index = tail;
    assign dispatch_out.has_dest  = entry.has_dest;
    assign dispatch_out.new_tag   = entry.new_tag;
    assign dispatch_out.old_tag   = entry.old_tag;

    assign rob_full = full;

    free_list free_list_inst (
        .clock         (clock),
        .reset         (reset),
        .alloc         (take_tag),
        .release_out   (retire_out),
        .rollback      (flush),
        .rollback_mask (rollback_mask),
        .alloc_tag     (alloc_tag),
        .free_empty    (free_empty)
    );

    map_table map_table_inst (
        .clock       (clock),
        .reset       (reset),
        .inst        (inst),
        .write       (take_tag),
        .new_tag     (alloc_tag),
        .restore     (flush),
        .restore_map (map_next),
        .has_dest    (has_dest),
        .rd          (rd),
        .old_tag     (old_tag)
    );

    reorder_buffer reorder_buffer_inst (
        .clock         (clock),
        .reset         (reset),
        .write         (accepted),
        .entry_in      (entry),
        .retire        (retire),
        .flush         (flush),
        .tail          (tail),
        .full          (full),
        .retire_out    (retire_out),
        .rollback_mask (rollback_mask)
    );

    arch_map arch_map_inst (
        .clock    (clock),
        .reset    (reset),
        .commit   (retire_out),
        .map_next (map_next)
    );

endmodule

// ==== rename/reorder_buffer.sv ====
// circular reorder buffer with count-based full, head retire view and rollback mask
`include "rename_settings.svh"

module reorder_buffer import rename_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  write,
    input  rob_entry_t            entry_in,
    input  logic                  retire,
    input  logic                  flush,
    output rob_idx_t              tail,
    output logic                  full,
    output retire_result_t        retire_out,
    output logic [`PHYS_REGS-1:0] rollback_mask
);

    // entry payload storage
    rob_entry_t [`ROB_DEPTH-1:0] entries;

    rob_idx_t               head_q;
    rob_idx_t               tail_q;
    // one extra bit so a full buffer is not mistaken for an empty one
    logic [`ROB_IDX_W:0]    count_q;
    logic                   empty;
    logic                   retire_fire;
    rob_entry_t             head_entry;
    rob_idx_t               head_next;

    assign empty = (count_q == '0);
    assign full  = (count_q == (`ROB_IDX_W + 1)'(`ROB_DEPTH));
    assign tail  = tail_q;

    // a strobe on an empty buffer is dropped
    assign retire_fire = retire && !empty;
    assign head_entry  = entries[head_q];
    assign head_next   = retire_fire ? head_q + rob_idx_t'(1) : head_q;

    // head view stays zero unless something actually retires
    always_comb begin
        retire_out = '0;
        if (retire_fire) begin
            retire_out.valid    = 1'b1;
            retire_out.rd       = head_entry.rd;
            retire_out.has_dest = head_entry.has_dest;
            retire_out.new_tag  = head_entry.new_tag;
            retire_out.old_tag  = head_entry.old_tag;
        end
    end

    // tags of everything the flush throws away
    // walk by offset from head so wrap-around needs no special case
    // offset 0 is skipped when it commits in this same cycle
    always_comb begin
        rob_idx_t idx;
        rollback_mask = '0;
        for (int k = 0; k < `ROB_DEPTH; k++) begin
            idx = head_q + rob_idx_t'(k);
            if (flush && (k < int'(count_q)) && !(retire_fire && k == 0)) begin
                if (entries[idx].has_dest) begin
                    rollback_mask[entries[idx].new_tag] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (write) begin
            entries[tail_q] <= entry_in;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush) begin
            // commit first, then drop the rest by closing the window at the head
            head_q  <= head_next;
            tail_q  <= head_next;
            count_q <= '0;
        end else begin
            head_q  <= head_next;
            if (write) begin
                tail_q <= tail_q + rob_idx_t'(1);
            end
            count_q <= count_q + (`ROB_IDX_W + 1)'(write) - (`ROB_IDX_W + 1)'(retire_fire);
        end
    end

    // a write while full would overwrite the head
    a_no_write_when_full: assert property (
        @(posedge clock) disable iff (reset) write |-> !full
    ) else $error("reorder buffer written while full");

    a_count_in_range: assert property (
        @(posedge clock) disable iff (reset) count_q <= (`ROB_IDX_W + 1)'(`ROB_DEPTH)
    ) else $error("reorder buffer count overflow");

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build the rename testbench with Verilator, run it, then look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module rename_tb -o rename_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/rename_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Verification passed" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1
